// ==== verilog/glbl_pkg.sv ====
package glbl_pkg;

   //--------------------------------------------------------------------------
   // Register bus widths
   //--------------------------------------------------------------------------
   localparam int DATA_W = 32;
   localparam int ADDR_W = 5;
   localparam int BE_W   = DATA_W / 8;

   typedef logic [DATA_W-1:0]    reg_data_t;
   typedef logic [ADDR_W-1:0]    reg_addr_t;
   typedef logic [BE_W-1:0]      reg_be_t;
   // One select bit per word address
   typedef logic [2**ADDR_W-1:0] reg_sel_t;

   //--------------------------------------------------------------------------
   // Address map (word addresses)
   //--------------------------------------------------------------------------
   localparam reg_addr_t ADDR_CHIP_ID    = 5'd0;
   localparam reg_addr_t ADDR_RST_CTRL   = 5'd1;
   localparam reg_addr_t ADDR_GLBL_CFG   = 5'd2;
   localparam reg_addr_t ADDR_INTR_MASK  = 5'd3;
   localparam reg_addr_t ADDR_INTR_STAT  = 5'd4;
   localparam reg_addr_t ADDR_MULTI_FUNC = 5'd5;
   localparam reg_addr_t ADDR_RANDOM     = 5'd9;
   localparam reg_addr_t ADDR_INTR_SET   = 5'd10;
   localparam reg_addr_t ADDR_MAILBOX    = 5'd15;
   localparam reg_addr_t ADDR_SCRATCH0   = 5'd16;
   localparam reg_addr_t ADDR_SCRATCH1   = 5'd17;
   localparam reg_addr_t ADDR_SCRATCH2   = 5'd18;
   localparam reg_addr_t ADDR_SCRATCH3   = 5'd19;

   // Manufacturer 8268, two cores, chip 7, revision 01
   localparam reg_data_t CHIP_ID_VAL = {16'h8268, 4'h2, 4'h7, 8'h01};

   // Reset values, overridable from the top level
   localparam reg_data_t RST_CTRL_RESET   = 32'h0000_0003;
   localparam reg_data_t MULTI_FUNC_RESET = 32'hC000_0000;
   localparam reg_data_t RNG_SEED_RESET   = 32'h1357_9BDF;

   //--------------------------------------------------------------------------
   // Bundled signals
   //--------------------------------------------------------------------------
   typedef struct packed {
      logic      cs;
      logic      wr;
      reg_addr_t addr;
      reg_data_t wdata;
      reg_be_t   be;
   } reg_req_t;

   // All active low
   typedef struct packed {
      logic [3:0] cpu_core_rst_n;
      logic       cpu_intf_rst_n;
      logic       qspim_rst_n;
      logic       sspim_rst_n;
      logic [1:0] uart_rst_n;
      logic       i2cm_rst_n;
      logic       usb_rst_n;
   } rst_ctrl_t;

   // Same bit order as the status word
   typedef struct packed {
      logic [23:0] gpio_intr;   // GPIO 31..8
      logic        ir;
      logic        rtc;
      logic        pwm;
      logic        usb;
      logic        i2cm;
      logic [2:0]  timer_intr;
   } intr_src_t;

   // Words owned by the configuration bank
   typedef struct packed {
      reg_data_t rst_ctrl;
      reg_data_t glbl_cfg;
      reg_data_t multi_func;
      reg_data_t mailbox;
      reg_data_t scratch0;
      reg_data_t scratch1;
      reg_data_t scratch2;
      reg_data_t scratch3;
   } cfg_words_t;

   typedef struct packed {
      cfg_words_t cfg;
      reg_data_t  intr_mask;
      reg_data_t  intr_stat;
      reg_data_t  random;
      reg_data_t  spare;
   } reg_bank_t;

   // Byte enables widened to a bit mask
   function automatic reg_data_t be_to_mask(input reg_be_t be);
      reg_data_t mask;
      for (int i = 0; i < BE_W; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      return mask;
   endfunction

endpackage

// ==== verilog/glbl_rand_gen.sv ====
module glbl_rand_gen #(
   parameter glbl_pkg::reg_data_t RNG_SEED = glbl_pkg::RNG_SEED_RESET
) (
   input  logic                mclk,
   input  logic                s_reset_n,
   input  logic                ack,
   output glbl_pkg::reg_data_t random
);

   logic feedback;

   // Fibonacci taps 32, 22, 2, 1
   assign feedback = random[31] ^ random[21] ^ random[1] ^ random[0];

   //--------------------------------------------------------------------------
   // One step per bus ack, read captures the pre-step value
   //--------------------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         random <= RNG_SEED;
      end else if (ack) begin
         // Shift left, feedback into bit 0
         random <= {random[30:0], feedback};
      end
   end

endmodule

// ==== verilog/glbl_bus_slave.sv ====
module glbl_bus_slave (
   input  logic                mclk,
   input  logic                s_reset_n,
   input  glbl_pkg::reg_req_t  req,
   input  glbl_pkg::reg_bank_t bank,
   output glbl_pkg::reg_data_t rdata,
   output logic                ack,
   output glbl_pkg::reg_sel_t  wr_sel,
   output glbl_pkg::reg_be_t   be
);

   glbl_pkg::reg_sel_t  addr_hit;
   glbl_pkg::reg_data_t rd_word;

   //--------------------------------------------------------------------------
   // Handshake: one ack cycle per access, read data captured with it
   //--------------------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         ack   <= 1'b0;
         rdata <= '0;
      end else if (req.cs && !ack) begin
         ack   <= 1'b1;
         rdata <= rd_word;
      end else begin
         // Data held until next access
         ack <= 1'b0;
      end
   end

   // Single one-hot decode of the word address
   always_comb begin
      addr_hit           = '0;
      addr_hit[req.addr] = 1'b1;
   end

   // Write strobe only in the ack cycle
   // Register lands at the edge closing that cycle
   assign wr_sel = (ack && req.cs && req.wr) ? addr_hit : '0;
   assign be     = req.be;

   //--------------------------------------------------------------------------
   // Read mux
   //--------------------------------------------------------------------------
   always_comb begin
      case (req.addr)
         glbl_pkg::ADDR_CHIP_ID:    rd_word = glbl_pkg::CHIP_ID_VAL;
         glbl_pkg::ADDR_RST_CTRL:   rd_word = bank.cfg.rst_ctrl;
         glbl_pkg::ADDR_GLBL_CFG:   rd_word = bank.cfg.glbl_cfg;
         glbl_pkg::ADDR_INTR_MASK:  rd_word = bank.intr_mask;
         glbl_pkg::ADDR_INTR_STAT:  rd_word = bank.intr_stat;
         glbl_pkg::ADDR_MULTI_FUNC: rd_word = bank.cfg.multi_func;
         glbl_pkg::ADDR_RANDOM:     rd_word = bank.random;
         // Set port reads back the status
         glbl_pkg::ADDR_INTR_SET:   rd_word = bank.intr_stat;
         glbl_pkg::ADDR_MAILBOX:    rd_word = bank.cfg.mailbox;
         glbl_pkg::ADDR_SCRATCH0:   rd_word = bank.cfg.scratch0;
         glbl_pkg::ADDR_SCRATCH1:   rd_word = bank.cfg.scratch1;
         glbl_pkg::ADDR_SCRATCH2:   rd_word = bank.cfg.scratch2;
         glbl_pkg::ADDR_SCRATCH3:   rd_word = bank.cfg.scratch3;
         // Unmapped, spare word is tied to zero
         default:                   rd_word = bank.spare;
      endcase
   end

endmodule

// ==== verilog/glbl_cfg_regs.sv ====
module glbl_cfg_regs #(
   parameter glbl_pkg::reg_data_t RST_CTRL_DEFAULT   = glbl_pkg::RST_CTRL_RESET,
   parameter glbl_pkg::reg_data_t MULTI_FUNC_DEFAULT = glbl_pkg::MULTI_FUNC_RESET
) (
   input  logic                  mclk,
   input  logic                  s_reset_n,
   input  glbl_pkg::reg_sel_t    wr_sel,
   input  glbl_pkg::reg_be_t     be,
   input  glbl_pkg::reg_data_t   wdata,
   output glbl_pkg::rst_ctrl_t   rst_ctrl,
   output logic                  soft_irq,
   output logic [2:0]            user_irq,
   output logic [15:0]           cfg_riscv_ctrl,
   output logic                  cfg_gpio_dgmode,
   output glbl_pkg::reg_data_t   cfg_multi_func_sel,
   output glbl_pkg::cfg_words_t  cfg_words
);

   localparam int NUM_WORDS = 8;

   // Word slots, same order as cfg_words_t
   localparam glbl_pkg::reg_addr_t WORD_ADDR [NUM_WORDS] = '{
      glbl_pkg::ADDR_RST_CTRL, glbl_pkg::ADDR_GLBL_CFG,
      glbl_pkg::ADDR_MULTI_FUNC, glbl_pkg::ADDR_MAILBOX,
      glbl_pkg::ADDR_SCRATCH0, glbl_pkg::ADDR_SCRATCH1,
      glbl_pkg::ADDR_SCRATCH2, glbl_pkg::ADDR_SCRATCH3
   };
   localparam glbl_pkg::reg_data_t WORD_INIT [NUM_WORDS] = '{
      RST_CTRL_DEFAULT, '0, MULTI_FUNC_DEFAULT, '0, '0, '0, '0, '0
   };

   glbl_pkg::reg_data_t byte_mask;
   glbl_pkg::reg_data_t word_q [NUM_WORDS];

   assign byte_mask = glbl_pkg::be_to_mask(be);

   //--------------------------------------------------------------------------
   // Byte-writable words
   //--------------------------------------------------------------------------
   for (genvar i = 0; i < NUM_WORDS; i++) begin : g_word
      glbl_pkg::reg_data_t q;

      always_ff @(posedge mclk or negedge s_reset_n) begin
         if (!s_reset_n) begin
            q <= WORD_INIT[i];
         end else if (wr_sel[WORD_ADDR[i]]) begin
            // Merge enabled bytes only
            q <= (q & ~byte_mask) | (wdata & byte_mask);
         end
      end

      assign word_q[i] = q;
   end

   assign cfg_words.rst_ctrl   = word_q[0];
   assign cfg_words.glbl_cfg   = word_q[1];
   assign cfg_words.multi_func = word_q[2];
   assign cfg_words.mailbox    = word_q[3];
   assign cfg_words.scratch0   = word_q[4];
   assign cfg_words.scratch1   = word_q[5];
   assign cfg_words.scratch2   = word_q[6];
   assign cfg_words.scratch3   = word_q[7];

   //--------------------------------------------------------------------------
   // Output fields
   //--------------------------------------------------------------------------
   // Reset control, bit 7 and upper bits are storage only
   assign rst_ctrl.cpu_intf_rst_n = word_q[0][0];
   assign rst_ctrl.qspim_rst_n    = word_q[0][1];
   assign rst_ctrl.sspim_rst_n    = word_q[0][2];
   assign rst_ctrl.uart_rst_n     = {word_q[0][6], word_q[0][3]};
   assign rst_ctrl.i2cm_rst_n     = word_q[0][4];
   assign rst_ctrl.usb_rst_n      = word_q[0][5];
   assign rst_ctrl.cpu_core_rst_n = word_q[0][11:8];

   // General config
   assign user_irq        = word_q[1][2:0];
   assign soft_irq        = word_q[1][3];
   assign cfg_gpio_dgmode = word_q[1][8];
   assign cfg_riscv_ctrl  = word_q[1][31:16];

   // Pin mux select straight from its word
   assign cfg_multi_func_sel = word_q[2];

endmodule

// ==== verilog/glbl_intr_ctrl.sv ====
module glbl_intr_ctrl (
   input  logic                 mclk,
   input  logic                 s_reset_n,
   input  glbl_pkg::reg_sel_t   wr_sel,
   input  glbl_pkg::reg_be_t    be,
   input  glbl_pkg::reg_data_t  wdata,
   input  glbl_pkg::intr_src_t  intr_src,
   output glbl_pkg::reg_data_t  irq_lines,
   output glbl_pkg::reg_data_t  intr_mask,
   output glbl_pkg::reg_data_t  intr_stat
);

   // Slow sources: {ir, rtc, usb, i2cm}
   logic [3:0] sync_q1;
   logic [3:0] sync_q2;

   glbl_pkg::reg_data_t byte_mask;
   glbl_pkg::reg_data_t hw_req;
   glbl_pkg::reg_data_t sw_set;
   glbl_pkg::reg_data_t sw_clr;
   glbl_pkg::reg_data_t intr_req;

   //--------------------------------------------------------------------------
   // Two-flop synchronizers for sources from other clock domains
   //--------------------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= {intr_src.ir, intr_src.rtc, intr_src.usb, intr_src.i2cm};
         sync_q2 <= sync_q1;
      end
   end

   // GPIO, PWM and timer already on mclk
   assign hw_req = {intr_src.gpio_intr, sync_q2[3], sync_q2[2], intr_src.pwm,
                    sync_q2[1], sync_q2[0], intr_src.timer_intr};

   assign byte_mask = glbl_pkg::be_to_mask(be);

   // Software set port and write-1-to-clear
   assign sw_set = wr_sel[glbl_pkg::ADDR_INTR_SET]  ? (wdata & byte_mask) : '0;
   assign sw_clr = wr_sel[glbl_pkg::ADDR_INTR_STAT] ? (wdata & byte_mask) : '0;

   assign intr_req = hw_req | sw_set;

   //--------------------------------------------------------------------------
   // Status and mask
   //--------------------------------------------------------------------------
   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_stat <= '0;
      end else begin
         // Request beats clear in the same cycle
         intr_stat <= (intr_stat & ~sw_clr) | intr_req;
      end
   end

   always_ff @(posedge mclk or negedge s_reset_n) begin
      if (!s_reset_n) begin
         intr_mask <= '0;
      end else if (wr_sel[glbl_pkg::ADDR_INTR_MASK]) begin
         intr_mask <= (intr_mask & ~byte_mask) | (wdata & byte_mask);
      end
   end

   // Unregistered to the core
   assign irq_lines = intr_mask & intr_stat;

endmodule

// ==== verilog/glbl_reg_top.sv ====
module glbl_reg_top #(
   parameter glbl_pkg::reg_data_t RST_CTRL_DEFAULT   = glbl_pkg::RST_CTRL_RESET,
   parameter glbl_pkg::reg_data_t MULTI_FUNC_DEFAULT = glbl_pkg::MULTI_FUNC_RESET,
   parameter glbl_pkg::reg_data_t RNG_SEED           = glbl_pkg::RNG_SEED_RESET
) (
   input  logic                 mclk,
   input  logic                 s_reset_n,
   // Register bus
   input  glbl_pkg::reg_req_t   req,
   output glbl_pkg::reg_data_t  rdata,
   output logic                 ack,
   // Interrupts
   input  glbl_pkg::intr_src_t  intr_src,
   output glbl_pkg::rst_ctrl_t  rst_ctrl,
   output glbl_pkg::reg_data_t  irq_lines,
   output logic                 soft_irq,
   output logic [2:0]           user_irq,
   // Configuration fields
   output logic [15:0]          cfg_riscv_ctrl,
   output logic                 cfg_gpio_dgmode,
   output glbl_pkg::reg_data_t  cfg_multi_func_sel
);

   glbl_pkg::reg_bank_t  bank;
   glbl_pkg::cfg_words_t cfg_words;
   glbl_pkg::reg_sel_t   wr_sel;
   glbl_pkg::reg_be_t    wr_be;
   glbl_pkg::reg_data_t  intr_mask;
   glbl_pkg::reg_data_t  intr_stat;
   glbl_pkg::reg_data_t  random;

   // Collect the readable words for the read mux
   assign bank.cfg       = cfg_words;
   assign bank.intr_mask = intr_mask;
   assign bank.intr_stat = intr_stat;
   assign bank.random    = random;
   assign bank.spare     = '0;

   glbl_bus_slave u_bus_slave (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .req       (req),
      .bank      (bank),
      .rdata     (rdata),
      .ack       (ack),
      .wr_sel    (wr_sel),
      .be        (wr_be)
   );

   glbl_cfg_regs #(
      .RST_CTRL_DEFAULT   (RST_CTRL_DEFAULT),
      .MULTI_FUNC_DEFAULT (MULTI_FUNC_DEFAULT)
   ) u_cfg_regs (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .wr_sel             (wr_sel),
      .be                 (wr_be),
      .wdata              (req.wdata),
      .rst_ctrl           (rst_ctrl),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_gpio_dgmode    (cfg_gpio_dgmode),
      .cfg_multi_func_sel (cfg_multi_func_sel),
      .cfg_words          (cfg_words)
   );

   glbl_intr_ctrl u_intr_ctrl (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .wr_sel    (wr_sel),
      .be        (wr_be),
      .wdata     (req.wdata),
      .intr_src  (intr_src),
      .irq_lines (irq_lines),
      .intr_mask (intr_mask),
      .intr_stat (intr_stat)
   );

   glbl_rand_gen #(
      .RNG_SEED (RNG_SEED)
   ) u_rand_gen (
      .mclk      (mclk),
      .s_reset_n (s_reset_n),
      .ack       (ack),
      .random    (random)
   );

endmodule

// ==== testbench/glbl_reg_sva.sv ====
module glbl_reg_sva (
   input logic                mclk,
   input logic                s_reset_n,
   input glbl_pkg::reg_req_t  req,
   input logic                ack,
   input glbl_pkg::reg_data_t irq_lines,
   input glbl_pkg::reg_data_t intr_mask,
   input glbl_pkg::reg_data_t intr_stat
);

   //--------------------------------------------------------------------------
   // Bus handshake
   //--------------------------------------------------------------------------
   // Single-cycle ack
   a_ack_one_cycle: assert property (@(posedge mclk) disable iff (!s_reset_n)
      ack |=> !ack)
      else $error("ack high in two consecutive cycles");

   // Ack only answers a chip select
   a_ack_after_cs: assert property (@(posedge mclk) disable iff (!s_reset_n)
      $rose(ack) |-> $past(req.cs))
      else $error("ack rose without cs");

   //--------------------------------------------------------------------------
   // Interrupt outputs
   //--------------------------------------------------------------------------
   a_irq_lines: assert property (@(posedge mclk) disable iff (!s_reset_n)
      irq_lines == (intr_mask & intr_stat))
      else $error("irq_lines differs from mask AND status");

endmodule

bind glbl_reg_top glbl_reg_sva u_sva (
   .mclk      (mclk),
   .s_reset_n (s_reset_n),
   .req       (req),
   .ack       (ack),
   .irq_lines (irq_lines),
   .intr_mask (intr_mask),
   .intr_stat (intr_stat)
);

// ==== testbench/tb_glbl_reg.sv ====
module tb_glbl_reg;

   localparam int NUM_TESTS       = 6;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

   logic                mclk;
   logic                s_reset_n;
   glbl_pkg::reg_req_t  req;
   glbl_pkg::reg_data_t rdata;
   logic                ack;
   glbl_pkg::intr_src_t intr_src;
   glbl_pkg::rst_ctrl_t rst_ctrl;
   glbl_pkg::reg_data_t irq_lines;
   logic                soft_irq;
   logic [2:0]          user_irq;
   logic [15:0]         cfg_riscv_ctrl;
   logic                cfg_gpio_dgmode;
   glbl_pkg::reg_data_t cfg_multi_func_sel;

   // Shadow copy of every register
   glbl_pkg::reg_data_t sh_rst;
   glbl_pkg::reg_data_t sh_cfg;
   glbl_pkg::reg_data_t sh_mfunc;
   glbl_pkg::reg_data_t sh_mask;
   glbl_pkg::reg_data_t sh_stat;
   glbl_pkg::reg_data_t sh_mbox;
   glbl_pkg::reg_data_t sh_rng;
   glbl_pkg::reg_data_t sh_scratch [4];

   logic [15:0] stim_lfsr;
   int          error_count = 0;
   int          check_count = 0;
   int          tests_failed = 0;
   int          test_num = 0;
   int          test_err_start = 0;
   string       test_name;

   // Pending comparisons for the compare process
   string               chk_name [$];
   glbl_pkg::reg_data_t chk_exp [$];
   glbl_pkg::reg_data_t chk_got [$];
   time                 chk_time [$];

   glbl_reg_top dut_i (
      .mclk               (mclk),
      .s_reset_n          (s_reset_n),
      .req                (req),
      .rdata              (rdata),
      .ack                (ack),
      .intr_src           (intr_src),
      .rst_ctrl           (rst_ctrl),
      .irq_lines          (irq_lines),
      .soft_irq           (soft_irq),
      .user_irq           (user_irq),
      .cfg_riscv_ctrl     (cfg_riscv_ctrl),
      .cfg_gpio_dgmode    (cfg_gpio_dgmode),
      .cfg_multi_func_sel (cfg_multi_func_sel)
   );

   initial begin
      mclk = 1'b0;
      forever #5 mclk = ~mclk;
   end

   //--------------------------------------------------------------------------
   // 16-bit stimulus LFSR with taps 16 14 13 11
   //--------------------------------------------------------------------------
   function automatic logic stim_bit();
      logic fb;
      fb        = stim_lfsr[15] ^ stim_lfsr[13] ^ stim_lfsr[12] ^ stim_lfsr[10];
      stim_lfsr = {stim_lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic glbl_pkg::reg_data_t rand_bits(input int n);
      glbl_pkg::reg_data_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], stim_bit()};
      end
      return v;
   endfunction

   //--------------------------------------------------------------------------
   // Reference model
   //--------------------------------------------------------------------------
   function automatic glbl_pkg::reg_data_t byte_lane_mask(input glbl_pkg::reg_be_t be);
      glbl_pkg::reg_data_t m;
      m = '0;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) m[8*i +: 8] = 8'hFF;
      end
      return m;
   endfunction

   // Generator step with taps 32 22 2 1 into bit 0
   function automatic glbl_pkg::reg_data_t rng_step(input glbl_pkg::reg_data_t v);
      return {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
   endfunction

   function automatic glbl_pkg::reg_data_t glbl_model_read(input glbl_pkg::reg_addr_t addr);
      case (addr)
         glbl_pkg::ADDR_CHIP_ID:    return 32'h8268_2701;
         glbl_pkg::ADDR_RST_CTRL:   return sh_rst;
         glbl_pkg::ADDR_GLBL_CFG:   return sh_cfg;
         glbl_pkg::ADDR_INTR_MASK:  return sh_mask;
         glbl_pkg::ADDR_INTR_STAT:  return sh_stat;
         glbl_pkg::ADDR_MULTI_FUNC: return sh_mfunc;
         glbl_pkg::ADDR_RANDOM:     return sh_rng;
         glbl_pkg::ADDR_INTR_SET:   return sh_stat;
         glbl_pkg::ADDR_MAILBOX:    return sh_mbox;
         glbl_pkg::ADDR_SCRATCH0:   return sh_scratch[0];
         glbl_pkg::ADDR_SCRATCH1:   return sh_scratch[1];
         glbl_pkg::ADDR_SCRATCH2:   return sh_scratch[2];
         glbl_pkg::ADDR_SCRATCH3:   return sh_scratch[3];
         default:                   return '0;
      endcase
   endfunction

   function automatic void model_write(input glbl_pkg::reg_addr_t addr,
                                       input glbl_pkg::reg_data_t wdata,
                                       input glbl_pkg::reg_be_t   be);
      glbl_pkg::reg_data_t m;
      m = byte_lane_mask(be);
      case (addr)
         glbl_pkg::ADDR_RST_CTRL:   sh_rst = (sh_rst & ~m) | (wdata & m);
         glbl_pkg::ADDR_GLBL_CFG:   sh_cfg = (sh_cfg & ~m) | (wdata & m);
         glbl_pkg::ADDR_INTR_MASK:  sh_mask = (sh_mask & ~m) | (wdata & m);
         // Write 1 clears a bit and the set port ORs one in
         glbl_pkg::ADDR_INTR_STAT:  sh_stat = sh_stat & ~(wdata & m);
         glbl_pkg::ADDR_INTR_SET:   sh_stat = sh_stat | (wdata & m);
         glbl_pkg::ADDR_MULTI_FUNC: sh_mfunc = (sh_mfunc & ~m) | (wdata & m);
         glbl_pkg::ADDR_MAILBOX:    sh_mbox = (sh_mbox & ~m) | (wdata & m);
         glbl_pkg::ADDR_SCRATCH0:   sh_scratch[0] = (sh_scratch[0] & ~m) | (wdata & m);
         glbl_pkg::ADDR_SCRATCH1:   sh_scratch[1] = (sh_scratch[1] & ~m) | (wdata & m);
         glbl_pkg::ADDR_SCRATCH2:   sh_scratch[2] = (sh_scratch[2] & ~m) | (wdata & m);
         glbl_pkg::ADDR_SCRATCH3:   sh_scratch[3] = (sh_scratch[3] & ~m) | (wdata & m);
         default:                   ;
      endcase
   endfunction

   // Reset fields from control bits 0..6 and 8..11
   function automatic glbl_pkg::rst_ctrl_t expected_resets(input glbl_pkg::reg_data_t w);
      glbl_pkg::rst_ctrl_t r;
      r.cpu_intf_rst_n = w[0];
      r.qspim_rst_n    = w[1];
      r.sspim_rst_n    = w[2];
      r.uart_rst_n     = {w[6], w[3]};
      r.i2cm_rst_n     = w[4];
      r.usb_rst_n      = w[5];
      r.cpu_core_rst_n = w[11:8];
      return r;
   endfunction

   //--------------------------------------------------------------------------
   // Bus and check tasks entered on a falling edge
   //--------------------------------------------------------------------------
   task automatic post_check(input string name, input glbl_pkg::reg_data_t exp,
                             input glbl_pkg::reg_data_t got);
      chk_name.push_back(name);
      chk_exp.push_back(exp);
      chk_got.push_back(got);
      chk_time.push_back($time);
   endtask

   task automatic bus_access(input logic wr, input glbl_pkg::reg_addr_t addr,
                             input glbl_pkg::reg_data_t wdata, input glbl_pkg::reg_be_t be,
                             output glbl_pkg::reg_data_t data);
      int waited;
      req.cs    = 1'b1;
      req.wr    = wr;
      req.addr  = addr;
      req.wdata = wdata;
      req.be    = be;
      @(negedge mclk);
      waited = 1;
      while (!ack && waited < 2) begin
         @(negedge mclk);
         waited++;
      end
      if (!ack) begin
         $display("No ack within two cycles for access to address %0d at %0t", addr, $time);
         error_count++;
      end
      data = rdata;
      // Hold cs through the ack cycle so a write lands
      @(negedge mclk);
      if (ack) begin
         $display("ack stayed high more than one cycle at %0t", $time);
         error_count++;
      end
      req.cs = 1'b0;
      req.wr = 1'b0;
      // Every ack steps the generator once
      sh_rng = rng_step(sh_rng);
   endtask

   task automatic write_reg(input glbl_pkg::reg_addr_t addr, input glbl_pkg::reg_data_t wdata,
                            input glbl_pkg::reg_be_t be);
      glbl_pkg::reg_data_t unused;
      bus_access(1'b1, addr, wdata, be, unused);
      model_write(addr, wdata, be);
   endtask

   task automatic read_check(input glbl_pkg::reg_addr_t addr);
      glbl_pkg::reg_data_t exp;
      glbl_pkg::reg_data_t got;
      exp = glbl_model_read(addr);
      bus_access(1'b0, addr, '0, '0, got);
      post_check($sformatf("rdata[addr %0d]", addr), exp, got);
   endtask

   task automatic check_outputs();
      post_check("rst_ctrl", 32'(expected_resets(sh_rst)), 32'(rst_ctrl));
      post_check("soft_irq", 32'(sh_cfg[3]), 32'(soft_irq));
      post_check("user_irq", 32'(sh_cfg[2:0]), 32'(user_irq));
      post_check("cfg_gpio_dgmode", 32'(sh_cfg[8]), 32'(cfg_gpio_dgmode));
      post_check("cfg_riscv_ctrl", 32'(sh_cfg[31:16]), 32'(cfg_riscv_ctrl));
      post_check("cfg_multi_func_sel", sh_mfunc, cfg_multi_func_sel);
      post_check("irq_lines", sh_mask & sh_stat, irq_lines);
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge mclk);
         if (ack) begin
            $display("ack high at %0t with no access in progress", $time);
            error_count++;
         end
      end
   endtask

   task automatic begin_test(input string name);
      test_num++;
      test_name      = name;
      test_err_start = error_count;
   endtask

   task automatic end_test();
      int errs;
      while (chk_got.size() != 0) @(posedge mclk);
      @(negedge mclk);
      errs = error_count - test_err_start;
      if (errs != 0) tests_failed++;
      $display("[test %0d] %s: %s, %0d errors", test_num, test_name,
               (errs == 0) ? "pass" : "fail", errs);
   endtask

   //--------------------------------------------------------------------------
   // Compare process
   //--------------------------------------------------------------------------
   initial begin
      string               name;
      glbl_pkg::reg_data_t exp;
      glbl_pkg::reg_data_t got;
      time                 t;
      forever begin
         @(posedge mclk);
         while (chk_got.size() > 0) begin
            name = chk_name.pop_front();
            exp  = chk_exp.pop_front();
            got  = chk_got.pop_front();
            t    = chk_time.pop_front();
            check_count++;
            if (got !== exp) begin
               $display("[ERROR] time %0t: %s expected 0x%08h, got 0x%08h", t, name, exp, got);
               error_count++;
            end
         end
      end
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge mclk);
      $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   //--------------------------------------------------------------------------
   // Test sequence
   //--------------------------------------------------------------------------
   initial begin
      glbl_pkg::reg_addr_t wr_list [9];
      glbl_pkg::reg_addr_t unmapped [7];
      glbl_pkg::intr_src_t pat;
      glbl_pkg::reg_data_t w;
      glbl_pkg::reg_be_t   b;
      s_reset_n = 1'b0;
      req       = '0;
      intr_src  = '0;
      stim_lfsr = 16'd91;
      sh_rst    = 32'h0000_0003;
      sh_cfg    = '0;
      sh_mfunc  = 32'hC000_0000;
      sh_mask   = '0;
      sh_stat   = '0;
      sh_mbox   = '0;
      sh_rng    = glbl_pkg::RNG_SEED_RESET;
      for (int i = 0; i < 4; i++) sh_scratch[i] = '0;
      wr_list = '{glbl_pkg::ADDR_RST_CTRL, glbl_pkg::ADDR_GLBL_CFG, glbl_pkg::ADDR_MULTI_FUNC,
                  glbl_pkg::ADDR_MAILBOX, glbl_pkg::ADDR_SCRATCH0, glbl_pkg::ADDR_SCRATCH1,
                  glbl_pkg::ADDR_SCRATCH2, glbl_pkg::ADDR_SCRATCH3, glbl_pkg::ADDR_INTR_MASK};
      unmapped = '{5'd6, 5'd8, 5'd11, 5'd14, 5'd20, 5'd27, 5'd31};
      repeat (10) @(negedge mclk);
      s_reset_n = 1'b1;
      @(negedge mclk);

      begin_test("reset values");
      // Bus outputs idle out of reset
      post_check("rdata", '0, rdata);
      post_check("ack", '0, 32'(ack));
      for (int i = 0; i < 32; i++) read_check(glbl_pkg::reg_addr_t'(i));
      check_outputs();
      end_test();

      begin_test("byte-enabled writes");
      for (int r = 0; r < 3; r++) begin
         for (int k = 0; k < 9; k++) begin
            w = rand_bits(32);
            b = glbl_pkg::reg_be_t'(rand_bits(4));
            write_reg(wr_list[k], w, b);
            read_check(wr_list[k]);
         end
      end
      // Unmapped words stay zero
      for (int k = 0; k < 7; k++) begin
         write_reg(unmapped[k], rand_bits(32), 4'hF);
         read_check(unmapped[k]);
      end
      for (int i = 0; i < 32; i++) read_check(glbl_pkg::reg_addr_t'(i));
      end_test();

      begin_test("output fields");
      for (int r = 0; r < 4; r++) begin
         write_reg(glbl_pkg::ADDR_GLBL_CFG, rand_bits(32), 4'hF);
         write_reg(glbl_pkg::ADDR_RST_CTRL, rand_bits(32), 4'hF);
         write_reg(glbl_pkg::ADDR_MULTI_FUNC, rand_bits(32), 4'hF);
         check_outputs();
      end
      end_test();

      begin_test("interrupts");
      write_reg(glbl_pkg::ADDR_INTR_MASK, rand_bits(32), 4'hF);
      // Mix of direct and synchronized sources
      pat     = rand_bits(32);
      pat.ir  = 1'b1;
      pat.usb = 1'b1;
      intr_src = pat;
      repeat (4) @(negedge mclk);
      intr_src = '0;
      // Let the synchronizers empty
      repeat (3) @(negedge mclk);
      sh_stat = sh_stat | glbl_pkg::reg_data_t'(pat);
      read_check(glbl_pkg::ADDR_INTR_STAT);
      check_outputs();
      // Partial write-1-to-clear
      w = rand_bits(32);
      b = glbl_pkg::reg_be_t'(rand_bits(4));
      write_reg(glbl_pkg::ADDR_INTR_STAT, w, b);
      read_check(glbl_pkg::ADDR_INTR_STAT);
      check_outputs();
      // Software set port
      write_reg(glbl_pkg::ADDR_INTR_SET, rand_bits(32), 4'hF);
      read_check(glbl_pkg::ADDR_INTR_SET);
      read_check(glbl_pkg::ADDR_INTR_STAT);
      check_outputs();
      // Request held across a clear keeps its bit
      pat            = '0;
      pat.pwm        = 1'b1;
      pat.timer_intr = 3'b010;
      intr_src = pat;
      @(negedge mclk);
      write_reg(glbl_pkg::ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'hF);
      sh_stat  = sh_stat | glbl_pkg::reg_data_t'(pat);
      intr_src = '0;
      @(negedge mclk);
      read_check(glbl_pkg::ADDR_INTR_STAT);
      check_outputs();
      write_reg(glbl_pkg::ADDR_INTR_STAT, 32'hFFFF_FFFF, 4'hF);
      read_check(glbl_pkg::ADDR_INTR_STAT);
      check_outputs();
      end_test();

      begin_test("random register");
      for (int i = 0; i < 8; i++) begin
         read_check(glbl_pkg::ADDR_RANDOM);
         // Writes count as acks too
         if (i == 3) write_reg(glbl_pkg::ADDR_SCRATCH2, rand_bits(32), 4'hF);
      end
      end_test();

      begin_test("handshake");
      for (int i = 0; i < 8; i++) begin
         idle_cycles(int'(rand_bits(2)));
         read_check(glbl_pkg::reg_addr_t'(rand_bits(5)));
      end
      idle_cycles(4);
      end_test();

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               test_num, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
verilog/glbl_pkg.sv
verilog/glbl_rand_gen.sv
verilog/glbl_bus_slave.sv
verilog/glbl_cfg_regs.sv
verilog/glbl_intr_ctrl.sv
verilog/glbl_reg_top.sv
testbench/glbl_reg_sva.sv
testbench/tb_glbl_reg.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_glbl_reg
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Test FAILED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)

# Fails on the fail message in the log or on a simulator error exit
run: compile
	@./$(BUILD)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
